// ==== dv/mailboxTests.mem ====
// test port op adr wrData rdData irq, all hex
// port a or b, op 0 read 1 write 2 idle, irq is {irqB, irqA}, a port of 0 ends the list
01 a 0 1 0000 0100 0
01 b 0 1 0000 0100 0
01 a 0 2 0000 0000 0
01 a 0 3 0000 0000 0
02 a 1 0 1111 0000 0
02 b 1 0 2222 0000 0
02 a 1 0 3333 0000 0
02 b 0 0 0000 1111 0
02 b 1 0 4444 0000 0
02 a 0 0 0000 2222 0
02 b 0 0 0000 3333 0
02 a 0 0 0000 4444 0
02 a 0 1 0000 0100 0
02 b 0 1 0000 0100 0
03 a 1 0 a001 0000 0
03 a 1 0 a002 0000 0
03 a 1 0 a003 0000 0
03 a 1 0 a004 0000 0
03 a 1 0 a005 0000 0
03 a 1 0 a006 0000 0
03 a 1 0 a007 0000 0
03 a 1 0 a008 0000 0
03 a 0 1 0000 0770 0
03 b 0 1 0000 0007 0
03 b 0 0 0000 a001 0
03 b 0 0 0000 a002 0
03 b 0 0 0000 a003 0
03 b 0 0 0000 a004 0
03 b 0 0 0000 a005 0
03 b 0 0 0000 a006 0
03 b 0 0 0000 a007 0
03 a 0 1 0000 0100 0
04 b 0 0 0000 0000 0
04 b 0 1 0000 0900 0
04 b 0 1 0000 0100 0
05 b 1 2 0003 0000 0
05 b 0 2 0000 0003 0
05 a 1 0 5001 0000 0
05 a 1 0 5002 0000 0
05 a 2 0 0000 0000 0
05 a 1 0 5003 0000 0
05 a 2 0 0000 0000 2
05 b 0 0 0000 5001 2
05 b 2 0 0000 0000 0
05 b 0 0 0000 5002 0
05 b 0 0 0000 5003 0
05 b 1 2 0000 0000 0
06 a 1 0 6001 0000 0
06 a 1 0 6002 0000 0
06 b 0 0 0000 6001 0
06 a 1 0 6003 0000 0
06 b 0 1 0000 0002 0
06 a 0 1 0000 0120 0
06 b 0 0 0000 6002 0
06 a 1 0 6004 0000 0
06 a 1 0 6005 0000 0
06 b 0 1 0000 0003 0
06 a 0 1 0000 0130 0
06 b 0 0 0000 6003 0
06 b 0 0 0000 6004 0
06 b 0 0 0000 6005 0
06 b 0 0 0000 0000 0
06 b 0 1 0000 0900 0
00 0 0 0 0000 0000 0

// ==== tb.f ====
verilog/mailboxPkg.sv
verilog/shiftFifo.sv
verilog/mailboxPort.sv
verilog/mailboxTop.sv
dv/mailboxTop_assertions.sv
dv/mailboxTb.sv

// ==== dv/mailboxTb.sv ====
// Testbench for the mailbox. Each line of the test file is one Wishbone access on
// port A or B, or an idle cycle, with the read data and irq lines it should produce.

`default_nettype none

module mailboxTb;

	import mailboxPkg::*;

	localparam int fieldCount = 7;	// Words per line of the test file
	localparam int maxOps = 128;
	localparam int ackTimeout = 10;

	localparam logic [15:0] opRead = 16'h0;
	localparam logic [15:0] opWrite = 16'h1;
	localparam logic [15:0] opIdle = 16'h2;

	logic [15:0] testMem [0:fieldCount*maxOps-1];

	logic clk;
	logic reset;
	logic cycA;
	logic stbA;
	logic weA;
	wbAddr adrA;
	mailboxData datWrA;
	mailboxData datRdA;
	logic ackA;
	logic irqA;
	logic cycB;
	logic stbB;
	logic weB;
	wbAddr adrB;
	mailboxData datWrB;
	mailboxData datRdB;
	logic ackB;
	logic irqB;

	mailboxTop mailboxTop_i (
		.clk(clk), .reset(reset),
		.cycA(cycA), .stbA(stbA), .weA(weA), .adrA(adrA), .datWrA(datWrA),
		.datRdA(datRdA), .ackA(ackA), .irqA(irqA),
		.cycB(cycB), .stbB(stbB), .weB(weB), .adrB(adrB), .datWrB(datWrB),
		.datRdB(datRdB), .ackB(ackB), .irqB(irqB)
	);

	always #10 clk = ~clk;

	task automatic stopWithFailure(input string reason);
		$display("%s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic checkValue(input string what, input int testNum, input int opIndex,
		input logic [15:0] expected, input logic [15:0] actual);
		if (actual !== expected)
			stopWithFailure($sformatf("error test %0d (op %0d) %s: expected %h, actual %h",
				testNum, opIndex, what, expected, actual));
	endtask

	// One classic cycle that starts 2 time units after a rising edge
	task automatic wbAccess(input logic onB, input logic write, input wbAddr addr,
		input mailboxData wrData, output mailboxData rdData);
		int waited;
		logic gotAck;

		waited = 0;
		gotAck = 1'b0;
		rdData = '0;
		if (onB) begin
			cycB = 1'b1;
			stbB = 1'b1;
			weB = write;
			adrB = addr;
			datWrB = wrData;
		end else begin
			cycA = 1'b1;
			stbA = 1'b1;
			weA = write;
			adrA = addr;
			datWrA = wrData;
		end
		while (!gotAck && waited < ackTimeout) begin
			@(posedge clk);
			#2;
			waited++;
			gotAck = onB ? ackB : ackA;
		end
		if (!gotAck) begin
			stopWithFailure($sformatf("port %s gave no ack within %0d cycles",
				onB ? "B" : "A", ackTimeout));
		end else begin
			rdData = onB ? datRdB : datRdA;	// Valid while ack is high
			cycA = 1'b0;
			stbA = 1'b0;
			cycB = 1'b0;
			stbB = 1'b0;
		end
	endtask

	initial begin
		int idx;
		int base;
		int testNum;
		logic onB;
		logic [15:0] opCode;
		mailboxData rdData;

		clk = 1'b0;
		reset = 1'b1;
		cycA = 1'b0;
		stbA = 1'b0;
		weA = 1'b0;
		adrA = '0;
		datWrA = '0;
		cycB = 1'b0;
		stbB = 1'b0;
		weB = 1'b0;
		adrB = '0;
		datWrB = '0;
		$readmemh("dv/mailboxTests.mem", testMem);

		repeat (2) @(posedge clk);
		#2;
		reset = 1'b0;
		repeat (2) @(posedge clk);	// FIFO reset arrives one cycle late
		#2;

		idx = 0;
		while (idx < maxOps && (testMem[idx*fieldCount+1] === 16'hA ||
			testMem[idx*fieldCount+1] === 16'hB)) begin
			base = idx * fieldCount;
			testNum = testMem[base];
			onB = (testMem[base+1] === 16'hB);
			opCode = testMem[base+2];
			if (opCode === opIdle) begin
				@(posedge clk);
				#2;
			end else if (opCode === opRead || opCode === opWrite) begin
				wbAccess(onB, opCode === opWrite, wbAddr'(testMem[base+3]),
					testMem[base+4], rdData);
				if (opCode === opRead)
					checkValue("read data", testNum, idx, testMem[base+5], rdData);
			end else begin
				stopWithFailure($sformatf("unknown operation code %h on line %0d",
					opCode, idx));
			end
			// The file gives irq as {irqB, irqA}
			checkValue("irq", testNum, idx, testMem[base+6], {14'd0, irqB, irqA});
			if (mailboxTop_i.mailboxChecks.failCount != 0)
				stopWithFailure($sformatf("a bound assertion failed during op %0d", idx));
			idx++;
		end

		@(posedge clk);	// The bound checks also see the cycle after the last ack
		#2;
		if (idx == 0)
			stopWithFailure("the test file held no operations");
		else if (mailboxTop_i.mailboxChecks.failCount != 0)
			stopWithFailure("a bound assertion failed at the end of the run");
		else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== dv/mailboxTop_assertions.sv ====
// Concurrent checks on the Wishbone handshake and the FIFO guards, bound into mailboxTop.
// Each failure raises $error and bumps a counter that the testbench watches.

`default_nettype none

module mailboxTop_assertions (
	input logic clk,
	input logic reset,
	input logic cycA,
	input logic stbA,
	input logic ackA,
	input logic irqA,
	input logic cycB,
	input logic stbB,
	input logic ackB,
	input logic irqB,
	input logic pushAtoB,
	input logic popAtoB,
	input logic fullAtoB,
	input logic emptyAtoB,
	input logic pushBtoA,
	input logic popBtoA,
	input logic fullBtoA,
	input logic emptyBtoA
);

	int failCount = 0;

	ackOneCycle: assert property (@(posedge clk) disable iff (reset)
		!(ackA && $past(ackA)) && !(ackB && $past(ackB)))
		else begin
			$error("ack stayed high for two cycles");
			failCount++;
		end

	ackAfterRequest: assert property (@(posedge clk) disable iff (reset)
		(!$rose(ackA) || $past(cycA && stbA)) && (!$rose(ackB) || $past(cycB && stbB)))
		else begin
			$error("ack rose without a request in the cycle before");
			failCount++;
		end

	// The ports must keep the FIFOs inside their range
	fifoGuard: assert property (@(posedge clk) disable iff (reset)
		!(pushAtoB && fullAtoB) && !(popAtoB && emptyAtoB) &&
		!(pushBtoA && fullBtoA) && !(popBtoA && emptyBtoA))
		else begin
			$error("FIFO pushed while full or popped while empty");
			failCount++;
		end

	quietAfterReset: assert property (@(posedge clk)
		reset |=> (!ackA && !irqA && !ackB && !irqB))
		else begin
			$error("ack or irq high after reset");
			failCount++;
		end

endmodule

bind mailboxTop mailboxTop_assertions mailboxChecks (
	.clk(clk), .reset(reset),
	.cycA(cycA), .stbA(stbA), .ackA(ackA), .irqA(irqA),
	.cycB(cycB), .stbB(stbB), .ackB(ackB), .irqB(irqB),
	.pushAtoB(pushAtoB), .popAtoB(popAtoB), .fullAtoB(fullAtoB), .emptyAtoB(emptyAtoB),
	.pushBtoA(pushBtoA), .popBtoA(popBtoA), .fullBtoA(fullBtoA), .emptyBtoA(emptyBtoA)
);

`default_nettype wire

// ==== verilog/mailboxTop.sv ====
// Top of the mailbox: two Wishbone ports and two FIFOs connected crosswise.
// Port A pushes into fifoAtoB, which port B pops, and the other way round.

`default_nettype none

module mailboxTop (
	input logic clk,
	input logic reset,
	input logic cycA,
	input logic stbA,
	input logic weA,
	input mailboxPkg::wbAddr adrA,
	input mailboxPkg::mailboxData datWrA,
	output mailboxPkg::mailboxData datRdA,
	output logic ackA,
	output logic irqA,
	input logic cycB,
	input logic stbB,
	input logic weB,
	input mailboxPkg::wbAddr adrB,
	input mailboxPkg::mailboxData datWrB,
	output mailboxPkg::mailboxData datRdB,
	output logic ackB,
	output logic irqB
);

	import mailboxPkg::*;

	mailboxData headAtoB, headBtoA;
	logic emptyAtoB, emptyBtoA;
	logic fullAtoB, fullBtoA;
	fifoCount cntAtoB, cntBtoA;
	logic pushAtoB, pushBtoA;
	logic popAtoB, popBtoA;

	mailboxPort portA (
		.clk(clk), .reset(reset),
		.cyc(cycA), .stb(stbA), .we(weA), .adr(adrA), .datWr(datWrA),
		.datRd(datRdA), .ack(ackA), .irq(irqA),
		.inHead(headBtoA), .inEmpty(emptyBtoA), .inCount(cntBtoA),
		.outFull(fullAtoB), .outCount(cntAtoB),
		.push(pushAtoB), .pop(popBtoA)
	);

	mailboxPort portB (
		.clk(clk), .reset(reset),
		.cyc(cycB), .stb(stbB), .we(weB), .adr(adrB), .datWr(datWrB),
		.datRd(datRdB), .ack(ackB), .irq(irqB),
		.inHead(headAtoB), .inEmpty(emptyAtoB), .inCount(cntAtoB),
		.outFull(fullBtoA), .outCount(cntBtoA),
		.push(pushBtoA), .pop(popAtoB)
	);

	shiftFifo #(.width(dataWidth)) fifoAtoB (
		.clk(clk), .reset(reset), .push(pushAtoB), .pop(popAtoB),
		.dIn(datWrA), .dOut(headAtoB),
		.full(fullAtoB), .empty(emptyAtoB), .cnt(cntAtoB)
	);

	shiftFifo #(.width(dataWidth)) fifoBtoA (
		.clk(clk), .reset(reset), .push(pushBtoA), .pop(popBtoA),
		.dIn(datWrB), .dOut(headBtoA),
		.full(fullBtoA), .empty(emptyBtoA), .cnt(cntBtoA)
	);

endmodule

`default_nettype wire

// ==== verilog/mailboxPort.sv ====
// Wishbone classic slave for one side of the mailbox.
// A data write pushes into the outgoing FIFO and a data read pops the incoming one.
// Status and irq level registers sit next to it, and the interrupt is registered.

`default_nettype none

module mailboxPort (
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input mailboxPkg::wbAddr adr,
	input mailboxPkg::mailboxData datWr,
	output mailboxPkg::mailboxData datRd,
	output logic ack,
	output logic irq,
	input mailboxPkg::mailboxData inHead,
	input logic inEmpty,
	input mailboxPkg::fifoCount inCount,
	input logic outFull,
	input mailboxPkg::fifoCount outCount,
	output logic push,
	output logic pop
);

	import mailboxPkg::*;

	// High in the cycle after reset, while the FIFOs are still clearing
	logic resetHold;

	logic req;
	logic isData;
	logic isStatus;
	logic isIrqLevel;

	logic dropWrite;
	logic emptyRead;
	logic statusRead;

	logic overflow;
	logic underflow;
	fifoCount irqLevel;

	mailboxData statusWord;
	mailboxData readValue;

	always_ff @(posedge clk) begin
		resetHold <= reset;
	end

	// A new request is taken only while ack is low, so ack lasts one cycle
	assign req = cyc && stb && !ack && !reset && !resetHold;

	assign isData = (adr == addrData);
	assign isStatus = (adr == addrStatus);
	assign isIrqLevel = (adr == addrIrqLevel);

	// FIFO operations happen in the cycle that produces ack
	assign push = req && we && isData && !outFull;
	assign pop = req && !we && isData && !inEmpty;

	assign dropWrite = req && we && isData && outFull;
	assign emptyRead = req && !we && isData && inEmpty;
	assign statusRead = req && !we && isStatus;

	always_comb begin
		statusWord = '0;
		statusWord[3:0] = inCount;
		statusWord[7:4] = outCount;
		statusWord[statusInEmpty] = inEmpty;
		statusWord[statusOutFull] = outFull;
		statusWord[statusOverflow] = overflow;
		statusWord[statusUnderflow] = underflow;
	end

	always_comb begin
		case (adr)
			addrData: readValue = inEmpty ? '0 : inHead;
			addrStatus: readValue = statusWord;
			addrIrqLevel: readValue = mailboxData'(irqLevel);
			default: readValue = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ack <= 1'b0;
			datRd <= '0;
		end else begin
			ack <= req;
			if (req)
				datRd <= we ? '0 : readValue;
		end
	end

	// A flag raised at the edge of a status read is kept
	always_ff @(posedge clk) begin
		if (reset) begin
			overflow <= 1'b0;
			underflow <= 1'b0;
		end else begin
			overflow <= (overflow && !statusRead) || dropWrite;
			underflow <= (underflow && !statusRead) || emptyRead;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			irqLevel <= '0;
		else if (req && we && isIrqLevel)
			irqLevel <= datWr[3:0];
	end

	// Level zero disables the interrupt
	always_ff @(posedge clk) begin
		if (reset)
			irq <= 1'b0;
		else
			irq <= (irqLevel != '0) && (inCount >= irqLevel);
	end

endmodule

`default_nettype wire

// ==== verilog/shiftFifo.sv ====
// Shift-register FIFO with seven entries. The head word sits in the first register
// and is readable at all times; a pop moves every entry one place toward it.
// Reset is spread through a register bank, so the FIFO clears one cycle late.
// Push when full or pop when empty is not checked here; the caller must avoid it.

`default_nettype none

module shiftFifo #(
	parameter int width = mailboxPkg::dataWidth
) (
	input logic clk,
	input logic reset,
	input logic push,
	input logic pop,
	input logic [width-1:0] dIn,
	output logic [width-1:0] dOut,
	output logic full,
	output logic empty,
	output mailboxPkg::fifoCount cnt
);

	import mailboxPkg::*;

	// Bit 0 resets the pointer, bit i resets data register i
	logic [fifoDepth:0] rstFan;

	fifoCount ptr;
	fifoCount ptrNxt;

	// Register 1 is the head of the queue
	logic [width-1:0] dataReg [1:fifoDepth];
	logic [width-1:0] shiftIn [1:fifoDepth];

	// Picks the next value of one data register
	function automatic logic [width-1:0] regUpdate(
		input fifoCount myPos,
		input fifoCount wrPos,
		input logic [width-1:0] wrData,
		input logic [width-1:0] shiftData,
		input logic [width-1:0] holdData,
		input logic wrEn,
		input logic rdEn
	);
		logic [width-1:0] result;

		if (wrEn && (myPos == wrPos))
			result = wrData;
		else if (rdEn)
			result = shiftData;
		else
			result = holdData;
		return result;
	endfunction

	always_ff @(posedge clk) begin
		rstFan <= {(fifoDepth + 1){reset}};
	end

	always_comb begin
		if (push && !pop)
			ptrNxt = ptr + 1'b1;
		else if (pop && !push)
			ptrNxt = ptr - 1'b1;
		else
			ptrNxt = ptr;	// Idle, or push and pop together
	end

	always_ff @(posedge clk) begin
		if (rstFan[0])
			ptr <= '0;
		else
			ptr <= ptrNxt;
	end

	// Each register's neighbor toward the tail, the last one pulls in zero
	always_comb begin
		shiftIn[fifoDepth] = '0;
		for (int i = 1; i < fifoDepth; i++) begin
			shiftIn[i] = dataReg[i + 1];
		end
	end

	// With push and pop together the write lands on the slot the tail shifts into
	always_ff @(posedge clk) begin
		for (int i = 1; i <= fifoDepth; i++) begin
			if (rstFan[i])
				dataReg[i] <= '0;
			else
				dataReg[i] <= regUpdate(fifoCount'(i), ptrNxt, dIn, shiftIn[i],
					dataReg[i], push, pop);
		end
	end

	always_comb begin
		empty = (ptr == '0);
		full = (ptr == fifoCount'(fifoDepth));
		cnt = ptr;
		dOut = dataReg[1];	// Head is combinational
	end

endmodule

`default_nettype wire

// ==== verilog/mailboxPkg.sv ====
// Shared types and register map of the two-sided Wishbone mailbox.
// Modules import it with a wildcard in their body and use scoped names in their ports.

`default_nettype none

package mailboxPkg;

	// Width of one mailbox word
	localparam int dataWidth = 16;

	typedef logic [dataWidth-1:0] mailboxData;

	// Register address inside one port
	typedef logic [1:0] wbAddr;

	// Occupancy of one FIFO, 0 to 7
	typedef logic [3:0] fifoCount;

	// A FIFO reports full at this many entries
	localparam int fifoDepth = 7;

	// Register map of a port, address 3 reads as zero
	localparam wbAddr addrData = 2'd0;
	localparam wbAddr addrStatus = 2'd1;
	localparam wbAddr addrIrqLevel = 2'd2;

	// Status word layout
	// Bits 3 to 0 hold the incoming count and bits 7 to 4 the outgoing count.
	// The flag bits follow, and everything above them reads as zero.
	localparam int statusInEmpty = 8;
	localparam int statusOutFull = 9;
	localparam int statusOverflow = 10;	// Sticky, cleared by a status read
	localparam int statusUnderflow = 11;	// Sticky, cleared by a status read

endpackage

`default_nettype wire
